/* dft_mem_pkg.sv */
//------------------------------------------------------------
// dft packet memory package
// bank geometry, controller phases and the divide-by-seven map
//------------------------------------------------------------
package dft_mem_pkg;

	localparam int num_banks = 7;
	localparam int max_radix = 5;
	localparam int addr_w = 12;
	localparam int row_w = 8;
	localparam int bank_idx_w = 3;

	// unused slot of a group
	localparam logic [bank_idx_w-1:0] no_bank = 3'd7;

	// owner of the bank ports
	typedef enum logic [bank_idx_w-1:0]
	{
		idle,
		sink,
		read,
		wait_wr,
		source
	} phase_t;

	// {row, bank} of a linear address, n div 7 and n mod 7
	// 2341/16384 is close enough to 1/7 to be exact below 4096
	function automatic logic [row_w+bank_idx_w-1:0] div7(input logic [addr_w-1:0] addr);
		logic [addr_w+13:0] prod;
		logic [addr_w-1:0] quot;
		logic [addr_w-1:0] rem;
		prod = addr * 14'd2341;
		quot = prod[addr_w+13:14];
		rem = addr - quot * 12'd7;
		return {quot[row_w-1:0], rem[bank_idx_w-1:0]};
	endfunction

endpackage

/* bank_array.sv */
//------------------------------------------------------------
// seven-bank sample store
// dual-port banks with phase-selected write and read sources
//------------------------------------------------------------
`timescale 1ns/1ns
module bank_array #(
	parameter int data_w = 30
) (
	input  logic clk,
	input  dft_mem_pkg::phase_t phase,
	input  logic [dft_mem_pkg::num_banks-1:0] sink_we,
	input  logic [dft_mem_pkg::row_w-1:0] sink_row,
	input  logic [data_w-1:0] sink_real,
	input  logic [data_w-1:0] sink_imag,
	input  logic [dft_mem_pkg::num_banks-1:0] wr_we,
	input  logic [dft_mem_pkg::num_banks-1:0][dft_mem_pkg::row_w-1:0] wr_row,
	input  logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] wr_real,
	input  logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] wr_imag,
	input  logic [dft_mem_pkg::num_banks-1:0] rd_re,
	input  logic [dft_mem_pkg::num_banks-1:0][dft_mem_pkg::row_w-1:0] rd_row,
	input  logic [dft_mem_pkg::num_banks-1:0] src_re,
	input  logic [dft_mem_pkg::row_w-1:0] src_row,
	output logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] rd_real,
	output logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] rd_imag
);

	localparam int nb = dft_mem_pkg::num_banks;
	localparam int rw = dft_mem_pkg::row_w;
	localparam int depth = 1 << rw;

	for (genvar k = 0; k < nb; k++)
	begin : g_bank
		logic [2*data_w-1:0] mem [depth];
		logic we;
		logic [rw-1:0] wa;
		logic [2*data_w-1:0] wd;
		logic re;
		logic [rw-1:0] ra;
		logic [2*data_w-1:0] q;

		// sink owns the write port only while the packet streams in
		always_comb
		begin
			if (phase == dft_mem_pkg::sink)
			begin
				we = sink_we[k];
				wa = sink_row;
				wd = {sink_real, sink_imag};
			end
			else
			begin
				we = wr_we[k];
				wa = wr_row[k];
				wd = {wr_real[k], wr_imag[k]};
			end
		end

		// group reads except in the output phase
		assign re = (phase == dft_mem_pkg::source) ? src_re[k] : rd_re[k];
		assign ra = (phase == dft_mem_pkg::source) ? src_row : rd_row[k];

		always_ff @(posedge clk)
		begin
			if (we)
				mem[wa] <= wd;
			if (re)
				q <= mem[ra];
		end

		assign rd_real[k] = q[2*data_w-1:data_w];
		assign rd_imag[k] = q[data_w-1:0];
	end

endmodule

/* sink_writer.sv */
//------------------------------------------------------------
// input sink, maps each sample to bank n mod 7, row n div 7
//------------------------------------------------------------
`timescale 1ns/1ns
module sink_writer #(
	parameter int in_w = 18,
	parameter int data_w = 30
) (
	input  logic clk,
	input  logic rst_n,
	input  dft_mem_pkg::phase_t phase,
	input  logic in_valid,
	input  logic [in_w-1:0] in_real,
	input  logic [in_w-1:0] in_imag,
	output logic [dft_mem_pkg::num_banks-1:0] sink_we,
	output logic [dft_mem_pkg::row_w-1:0] sink_row,
	output logic [data_w-1:0] sink_real,
	output logic [data_w-1:0] sink_imag,
	output logic sink_done
);

	localparam int nb = dft_mem_pkg::num_banks;
	localparam int aw = dft_mem_pkg::addr_w;

	logic [aw-1:0] cnt;
	logic [dft_mem_pkg::row_w-1:0] row;
	logic [dft_mem_pkg::bank_idx_w-1:0] bank;
	logic accept;

	// sop arrives while the controller is still idle
	assign accept = in_valid &&
		(phase == dft_mem_pkg::idle || phase == dft_mem_pkg::sink);
	assign {row, bank} = dft_mem_pkg::div7(cnt);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt <= '0;
			sink_we <= '0;
			sink_done <= 1'b0;
		end
		else
		begin
			if (accept)
				cnt <= cnt + 1'b1;
			else if (phase != dft_mem_pkg::sink)
				cnt <= '0;
			sink_we <= accept ? ({{(nb-1){1'b0}}, 1'b1} << bank) : '0;
			// last write happens on this edge
			sink_done <= (|sink_we) && !accept && (phase == dft_mem_pkg::sink);
		end
	end

	always_ff @(posedge clk)
	begin
		sink_row <= row;
		sink_real <= {{(data_w-in_w){in_real[in_w-1]}}, in_real};
		sink_imag <= {{(data_w-in_w){in_imag[in_w-1]}}, in_imag};
	end

endmodule

/* group_reader.sv */
//------------------------------------------------------------
// group reader, issues one group of consecutive addresses per
// cycle and routes the bank outputs to the engine slots
//------------------------------------------------------------
`timescale 1ns/1ns
module group_reader #(
	parameter int data_w = 30
) (
	input  logic clk,
	input  logic rst_n,
	input  logic stage_start,
	input  logic [2:0] factor_q,
	input  logic [dft_mem_pkg::addr_w-1:0] dftpts_q,
	input  logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] rd_real,
	input  logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] rd_imag,
	output logic [dft_mem_pkg::num_banks-1:0] rd_re,
	output logic [dft_mem_pkg::num_banks-1:0][dft_mem_pkg::row_w-1:0] rd_row,
	output logic rd_done,
	output logic pe_out_valid,
	output logic [dft_mem_pkg::max_radix-1:0][data_w-1:0] pe_out_real,
	output logic [dft_mem_pkg::max_radix-1:0][data_w-1:0] pe_out_imag,
	output logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::bank_idx_w-1:0] pe_out_bank,
	output logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::row_w-1:0] pe_out_row
);

	localparam int nb = dft_mem_pkg::num_banks;
	localparam int mr = dft_mem_pkg::max_radix;
	localparam int aw = dft_mem_pkg::addr_w;
	localparam int rw = dft_mem_pkg::row_w;
	localparam int bw = dft_mem_pkg::bank_idx_w;

	logic active;
	logic [aw-1:0] base;
	logic last_grp;
	logic [mr-1:0][bw-1:0] slot_bank;
	logic [mr-1:0][rw-1:0] slot_row;
	logic [mr-1:0][bw-1:0] bank_d1;
	logic [mr-1:0][rw-1:0] row_d1;
	logic vld_d1;
	logic [nb-1:0] hit;
	logic [nb-1:0][rw-1:0] hit_row;

	assign last_grp = (base + aw'(factor_q)) >= dftpts_q;

	//------------------------------------------------------------
	// address generation
	//------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			base <= '0;
			rd_done <= 1'b0;
		end
		else
		begin
			if (stage_start)
			begin
				active <= 1'b1;
				base <= '0;
			end
			else if (active)
			begin
				base <= base + aw'(factor_q);
				if (last_grp)
					active <= 1'b0;
			end
			rd_done <= active && last_grp;
		end
	end

	// slots beyond the factor stay empty
	always_comb
	begin
		logic [bw-1:0] b;
		logic [rw-1:0] r;
		for (int j = 0; j < mr; j++)
		begin
			{r, b} = dft_mem_pkg::div7(base + aw'(j));
			slot_row[j] = r;
			slot_bank[j] = (j < factor_q) ? b : dft_mem_pkg::no_bank;
		end
	end

	//------------------------------------------------------------
	// bank crossbar, slot to bank
	//------------------------------------------------------------
	always_comb
	begin
		hit = '0;
		hit_row = '0;
		for (int k = 0; k < nb; k++)
			for (int j = 0; j < mr; j++)
				if (slot_bank[j] == bw'(k))
				begin
					hit[k] = 1'b1;
					hit_row[k] = slot_row[j];
				end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_re <= '0;
			vld_d1 <= 1'b0;
			pe_out_valid <= 1'b0;
		end
		else
		begin
			rd_re <= active ? hit : '0;
			vld_d1 <= active;
			pe_out_valid <= vld_d1;
		end
	end

	// slot fields follow the bank read latency
	always_ff @(posedge clk)
	begin
		rd_row <= hit_row;
		bank_d1 <= slot_bank;
		row_d1 <= slot_row;
		pe_out_bank <= bank_d1;
		pe_out_row <= row_d1;
	end

	// back crossbar, bank to slot
	for (genvar j = 0; j < mr; j++)
	begin : g_slot
		assign pe_out_real[j] = (pe_out_bank[j] == dft_mem_pkg::no_bank) ? '0 :
			rd_real[pe_out_bank[j]];
		assign pe_out_imag[j] = (pe_out_bank[j] == dft_mem_pkg::no_bank) ? '0 :
			rd_imag[pe_out_bank[j]];
	end

endmodule

/* result_writer.sv */
//------------------------------------------------------------
// result writer, routes engine result slots back to their banks
//------------------------------------------------------------
`timescale 1ns/1ns
module result_writer #(
	parameter int data_w = 30
) (
	input  logic clk,
	input  logic rst_n,
	input  dft_mem_pkg::phase_t phase,
	input  logic pe_in_valid,
	input  logic [dft_mem_pkg::max_radix-1:0][data_w-1:0] pe_in_real,
	input  logic [dft_mem_pkg::max_radix-1:0][data_w-1:0] pe_in_imag,
	input  logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::bank_idx_w-1:0] pe_in_bank,
	input  logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::row_w-1:0] pe_in_row,
	output logic [dft_mem_pkg::num_banks-1:0] wr_we,
	output logic [dft_mem_pkg::num_banks-1:0][dft_mem_pkg::row_w-1:0] wr_row,
	output logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] wr_real,
	output logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] wr_imag,
	output logic [dft_mem_pkg::addr_w-1:0] wr_count
);

	localparam int nb = dft_mem_pkg::num_banks;
	localparam int mr = dft_mem_pkg::max_radix;
	localparam int bw = dft_mem_pkg::bank_idx_w;

	dft_mem_pkg::phase_t phase_q;
	logic [nb-1:0] hit;

	// no_bank never matches a real bank index
	always_comb
	begin
		hit = '0;
		for (int k = 0; k < nb; k++)
			for (int j = 0; j < mr; j++)
				if (pe_in_bank[j] == bw'(k))
					hit[k] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_we <= '0;
			wr_count <= '0;
			phase_q <= dft_mem_pkg::idle;
		end
		else
		begin
			wr_we <= pe_in_valid ? hit : '0;
			phase_q <= phase;
			// fresh count for every stage
			if (phase == dft_mem_pkg::read && phase_q != dft_mem_pkg::read)
				wr_count <= '0;
			else if (pe_in_valid)
				wr_count <= wr_count + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int k = 0; k < nb; k++)
			for (int j = 0; j < mr; j++)
				if (pe_in_bank[j] == bw'(k))
				begin
					wr_row[k] <= pe_in_row[j];
					wr_real[k] <= pe_in_real[j];
					wr_imag[k] <= pe_in_imag[j];
				end
	end

endmodule

/* source_reader.sv */
//------------------------------------------------------------
// source reader, streams the finished packet out in address order
//------------------------------------------------------------
`timescale 1ns/1ns
module source_reader #(
	parameter int data_w = 30
) (
	input  logic clk,
	input  logic rst_n,
	input  logic src_start,
	input  logic [dft_mem_pkg::addr_w-1:0] dftpts_q,
	input  logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] rd_real,
	input  logic [dft_mem_pkg::num_banks-1:0][data_w-1:0] rd_imag,
	output logic [dft_mem_pkg::num_banks-1:0] src_re,
	output logic [dft_mem_pkg::row_w-1:0] src_row,
	output logic src_done,
	output logic out_valid,
	output logic out_sop,
	output logic out_eop,
	output logic [data_w-1:0] out_real,
	output logic [data_w-1:0] out_imag
);

	localparam int nb = dft_mem_pkg::num_banks;
	localparam int aw = dft_mem_pkg::addr_w;

	logic active;
	logic [aw-1:0] addr;
	logic [dft_mem_pkg::bank_idx_w-1:0] bank;
	logic [dft_mem_pkg::bank_idx_w-1:0] bank_q;
	logic vld_q;
	logic first_q;
	logic last_q;

	assign {src_row, bank} = dft_mem_pkg::div7(addr);
	assign src_re = active ? ({{(nb-1){1'b0}}, 1'b1} << bank) : '0;
	assign src_done = out_eop;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			addr <= '0;
			vld_q <= 1'b0;
			out_valid <= 1'b0;
			out_sop <= 1'b0;
			out_eop <= 1'b0;
		end
		else
		begin
			if (src_start)
			begin
				active <= 1'b1;
				addr <= '0;
			end
			else if (active)
			begin
				addr <= addr + 1'b1;
				if (addr == dftpts_q - 1'b1)
					active <= 1'b0;
			end
			// framing lines up with the bank output
			vld_q <= active;
			out_valid <= vld_q;
			out_sop <= vld_q && first_q;
			out_eop <= vld_q && last_q;
		end
	end

	always_ff @(posedge clk)
	begin
		bank_q <= bank;
		first_q <= (addr == '0);
		last_q <= (addr == dftpts_q - 1'b1);
		out_real <= rd_real[bank_q];
		out_imag <= rd_imag[bank_q];
	end

endmodule

/* mem_ctrl.sv */
//------------------------------------------------------------
// memory controller, phase FSM, stage count and packet settings
//------------------------------------------------------------
`timescale 1ns/1ns
module mem_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic in_sop,
	input  logic [dft_mem_pkg::addr_w-1:0] dftpts,
	input  logic [2:0] factor,
	input  logic [2:0] stages,
	input  logic sink_done,
	input  logic rd_done,
	input  logic [dft_mem_pkg::addr_w-1:0] wr_count,
	input  logic src_done,
	output dft_mem_pkg::phase_t phase,
	output logic stage_start,
	output logic src_start,
	output logic busy,
	output logic [dft_mem_pkg::addr_w-1:0] dftpts_q,
	output logic [2:0] factor_q
);

	localparam int aw = dft_mem_pkg::addr_w;

	logic [2:0] stages_q;
	logic [2:0] stage_cnt;
	logic [aw-1:0] grp_sum;
	logic [aw-1:0] num_grp;

	assign busy = (phase != dft_mem_pkg::idle);

	//------------------------------------------------------------
	// phase FSM
	//------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase <= dft_mem_pkg::idle;
			stage_cnt <= '0;
			stage_start <= 1'b0;
			src_start <= 1'b0;
		end
		else
		begin
			stage_start <= 1'b0;
			src_start <= 1'b0;
			case (phase)
			dft_mem_pkg::idle:
				if (in_sop)
					phase <= dft_mem_pkg::sink;
			dft_mem_pkg::sink:
				if (sink_done)
				begin
					phase <= dft_mem_pkg::read;
					stage_cnt <= 3'd1;
					stage_start <= 1'b1;
				end
			dft_mem_pkg::read:
				if (rd_done)
					phase <= dft_mem_pkg::wait_wr;
			dft_mem_pkg::wait_wr:
				if (wr_count == num_grp)
				begin
					if (stage_cnt == stages_q)
					begin
						phase <= dft_mem_pkg::source;
						src_start <= 1'b1;
					end
					else
					begin
						phase <= dft_mem_pkg::read;
						stage_cnt <= stage_cnt + 1'b1;
						stage_start <= 1'b1;
					end
				end
			dft_mem_pkg::source:
				if (src_done)
					phase <= dft_mem_pkg::idle;
			default:
				phase <= dft_mem_pkg::idle;
			endcase
		end
	end

	// group count dftpts/factor by repeated add during the sink
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			grp_sum <= '0;
			num_grp <= '0;
		end
		else if (phase == dft_mem_pkg::idle)
		begin
			grp_sum <= '0;
			num_grp <= '0;
		end
		else if (phase == dft_mem_pkg::sink && grp_sum < dftpts_q)
		begin
			grp_sum <= grp_sum + aw'(factor_q);
			num_grp <= num_grp + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (phase == dft_mem_pkg::idle && in_sop)
		begin
			dftpts_q <= dftpts;
			factor_q <= factor;
			stages_q <= stages;
		end
	end

endmodule

/* dft_mem_top.sv */
//------------------------------------------------------------
// dft packet memory top, controller plus seven-bank datapath
//------------------------------------------------------------
`timescale 1ns/1ns
module dft_mem_top #(
	parameter int in_w = 18,
	parameter int data_w = 30
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic in_sop,
	input  logic [in_w-1:0] in_real,
	input  logic [in_w-1:0] in_imag,
	input  logic [dft_mem_pkg::addr_w-1:0] dftpts,
	input  logic [2:0] factor,
	input  logic [2:0] stages,
	output logic pe_out_valid,
	output logic [dft_mem_pkg::max_radix-1:0][data_w-1:0] pe_out_real,
	output logic [dft_mem_pkg::max_radix-1:0][data_w-1:0] pe_out_imag,
	output logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::bank_idx_w-1:0] pe_out_bank,
	output logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::row_w-1:0] pe_out_row,
	input  logic pe_in_valid,
	input  logic [dft_mem_pkg::max_radix-1:0][data_w-1:0] pe_in_real,
	input  logic [dft_mem_pkg::max_radix-1:0][data_w-1:0] pe_in_imag,
	input  logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::bank_idx_w-1:0] pe_in_bank,
	input  logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::row_w-1:0] pe_in_row,
	output logic out_valid,
	output logic out_sop,
	output logic out_eop,
	output logic [data_w-1:0] out_real,
	output logic [data_w-1:0] out_imag,
	output logic busy
);

	localparam int nb = dft_mem_pkg::num_banks;
	localparam int aw = dft_mem_pkg::addr_w;
	localparam int rw = dft_mem_pkg::row_w;

	// control
	dft_mem_pkg::phase_t phase;
	logic stage_start;
	logic src_start;
	logic [aw-1:0] dftpts_q;
	logic [2:0] factor_q;
	logic sink_done;
	logic rd_done;
	logic [aw-1:0] wr_count;
	logic src_done;

	// bank ports
	logic [nb-1:0] sink_we;
	logic [rw-1:0] sink_row;
	logic [data_w-1:0] sink_real;
	logic [data_w-1:0] sink_imag;
	logic [nb-1:0] wr_we;
	logic [nb-1:0][rw-1:0] wr_row;
	logic [nb-1:0][data_w-1:0] wr_real;
	logic [nb-1:0][data_w-1:0] wr_imag;
	logic [nb-1:0] rd_re;
	logic [nb-1:0][rw-1:0] rd_row;
	logic [nb-1:0] src_re;
	logic [rw-1:0] src_row;
	logic [nb-1:0][data_w-1:0] rd_real;
	logic [nb-1:0][data_w-1:0] rd_imag;

	mem_ctrl u_mem_ctrl (.*);

	bank_array #(.data_w(data_w)) u_bank_array (.*);

	sink_writer #(.in_w(in_w), .data_w(data_w)) u_sink_writer (.*);

	group_reader #(.data_w(data_w)) u_group_reader (.*);

	result_writer #(.data_w(data_w)) u_result_writer (.*);

	source_reader #(.data_w(data_w)) u_source_reader (.*);

endmodule

/* tb_dft_mem_asserts.sv */
//------------------------------------------------------------
// concurrent checks on output framing, group banks and sink writes
//------------------------------------------------------------
`timescale 1ns/1ns
module tb_dft_mem_asserts (
	input  logic clk,
	input  logic rst_n,
	input  logic out_valid,
	input  logic out_sop,
	input  logic out_eop,
	input  logic pe_out_valid,
	input  logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::bank_idx_w-1:0] pe_out_bank,
	input  dft_mem_pkg::phase_t phase,
	input  logic [dft_mem_pkg::num_banks-1:0] sink_we
);

	int fail_count = 0;

	// empty slots may repeat, real banks may not
	function automatic logic banks_distinct(
		input logic [dft_mem_pkg::max_radix-1:0][dft_mem_pkg::bank_idx_w-1:0] b
	);
		for (int j = 0; j < dft_mem_pkg::max_radix; j++)
			for (int k = j + 1; k < dft_mem_pkg::max_radix; k++)
				if (b[j] != dft_mem_pkg::no_bank && b[j] == b[k])
					return 1'b0;
		return 1'b1;
	endfunction

	a_framing: assert property (@(posedge clk) disable iff (!rst_n)
		(out_sop || out_eop) |-> out_valid)
	else
	begin
		$error("out_sop or out_eop seen without out_valid");
		fail_count++;
	end

	a_bank_conflict: assert property (@(posedge clk) disable iff (!rst_n)
		pe_out_valid |-> banks_distinct(pe_out_bank))
	else
	begin
		$error("two slots of one group name the same bank");
		fail_count++;
	end

	a_sink_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		(phase == dft_mem_pkg::sink) |-> $onehot0(sink_we))
	else
	begin
		$error("more than one bank written in one sink cycle");
		fail_count++;
	end

endmodule

bind dft_mem_top tb_dft_mem_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.out_valid(out_valid),
	.out_sop(out_sop),
	.out_eop(out_eop),
	.pe_out_valid(pe_out_valid),
	.pe_out_bank(pe_out_bank),
	.phase(phase),
	.sink_we(sink_we)
);

/* tb_checker.sv */
//------------------------------------------------------------
// output checker, compares each packet with the rotation rule
//------------------------------------------------------------
`timescale 1ns/1ns
module tb_checker #(
	parameter int in_w = 18,
	parameter int data_w = 30
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_sop,
	input  logic busy,
	input  logic pe_out_valid,
	input  logic out_valid,
	input  logic out_sop,
	input  logic out_eop,
	input  logic [data_w-1:0] out_real,
	input  logic [data_w-1:0] out_imag,
	input  int pkt_dftpts,
	input  int pkt_factor,
	input  int pkt_stages,
	input  logic [31:0] pkt_base,
	input  logic [31:0] pkt_first,
	input  logic [31:0] pkt_last,
	output int pkts_done,
	output int check_errors,
	output int pkts_passed
);

	logic seen_sop = 1'b0;
	int idx = 0;
	int pkt_errs = 0;
	logic [data_w-1:0] first_real;

	function automatic logic [data_w-1:0] widen(input logic [in_w-1:0] v);
		return {{(data_w-in_w){v[in_w-1]}}, v};
	endfunction

	// input sample that lands on output address a after all stages
	function automatic int source_index(input int a);
		int f;
		f = pkt_factor;
		return (a / f) * f + ((a % f + pkt_stages) % f);
	endfunction

	task automatic close_packet(input logic complete, input logic [data_w-1:0] last_real);
		if (!complete)
		begin
			$display("packet %0d ended after %0d of %0d samples", pkts_done + 1, idx + 1,
				pkt_dftpts);
			pkt_errs++;
		end
		if (first_real != pkt_first[data_w-1:0])
		begin
			$display("** Error first out_real: got %h, file gives %h", first_real,
				pkt_first[data_w-1:0]);
			pkt_errs++;
		end
		if (complete && last_real != pkt_last[data_w-1:0])
		begin
			$display("** Error last out_real: got %h, file gives %h", last_real,
				pkt_last[data_w-1:0]);
			pkt_errs++;
		end
		pkts_done++;
		if (pkt_errs == 0)
		begin
			pkts_passed++;
			$display("packet %0d: dftpts %0d factor %0d stages %0d ok", pkts_done,
				pkt_dftpts, pkt_factor, pkt_stages);
		end
		else
			$display("packet %0d: dftpts %0d factor %0d stages %0d, %0d mismatches",
				pkts_done, pkt_dftpts, pkt_factor, pkt_stages, pkt_errs);
		check_errors += pkt_errs;
		pkt_errs = 0;
		idx = 0;
	endtask

	initial
	begin
		pkts_done = 0;
		check_errors = 0;
		pkts_passed = 0;
	end

	always @(posedge clk)
	begin
		int s;
		logic [data_w-1:0] exp_real;
		logic [data_w-1:0] exp_imag;
		if (rst_n)
		begin
			// quiet outputs until the first packet arrives
			if (!seen_sop)
			begin
				if (busy || out_valid || pe_out_valid)
				begin
					$display("** Error before first sop: busy %h out_valid %h pe_out_valid %h",
						busy, out_valid, pe_out_valid);
					check_errors++;
				end
				if (in_sop)
					seen_sop = 1'b1;
			end
			if (out_valid)
			begin
				s = source_index(idx);
				exp_real = widen(in_w'(pkt_base + 32'(s)));
				exp_imag = widen(in_w'(32'd0 - pkt_base - 32'(s)));
				if (out_real != exp_real)
				begin
					$display("** Error out_real at %0d: got %h, expected %h", idx, out_real,
						exp_real);
					pkt_errs++;
				end
				if (out_imag != exp_imag)
				begin
					$display("** Error out_imag at %0d: got %h, expected %h", idx, out_imag,
						exp_imag);
					pkt_errs++;
				end
				if (out_sop !== (idx == 0))
				begin
					$display("** Error out_sop at %0d: got %h, expected %h", idx, out_sop,
						idx == 0);
					pkt_errs++;
				end
				if (out_eop !== (idx == pkt_dftpts - 1))
				begin
					$display("** Error out_eop at %0d: got %h, expected %h", idx, out_eop,
						idx == pkt_dftpts - 1);
					pkt_errs++;
				end
				if (idx == 0)
					first_real = out_real;
				if (out_eop || idx == pkt_dftpts - 1)
					close_packet(idx == pkt_dftpts - 1, out_real);
				else
					idx++;
			end
			else if (idx != 0)
			begin
				$display("out_valid dropped in the middle of packet %0d", pkts_done + 1);
				pkt_errs++;
				idx--;
				close_packet(1'b0, '0);
			end
		end
	end

endmodule

/* tb_dft_mem.sv */
//------------------------------------------------------------
// dft packet memory testbench, file-driven packets and a
// radix engine model that rotates each group by one slot
//------------------------------------------------------------
`timescale 1ns/1ns
module tb_dft_mem;

	localparam int in_w = 18;
	localparam int data_w = 30;
	localparam int mr = dft_mem_pkg::max_radix;
	localparam int bw = dft_mem_pkg::bank_idx_w;
	localparam int rw = dft_mem_pkg::row_w;
	localparam int max_pkts = 16;
	localparam int wait_limit = 20000;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_sop;
	logic [in_w-1:0] in_real;
	logic [in_w-1:0] in_imag;
	logic [dft_mem_pkg::addr_w-1:0] dftpts;
	logic [2:0] factor;
	logic [2:0] stages;
	logic pe_out_valid;
	logic [mr-1:0][data_w-1:0] pe_out_real;
	logic [mr-1:0][data_w-1:0] pe_out_imag;
	logic [mr-1:0][bw-1:0] pe_out_bank;
	logic [mr-1:0][rw-1:0] pe_out_row;
	logic pe_in_valid = 1'b0;
	logic [mr-1:0][data_w-1:0] pe_in_real = '0;
	logic [mr-1:0][data_w-1:0] pe_in_imag = '0;
	logic [mr-1:0][bw-1:0] pe_in_bank = {mr{dft_mem_pkg::no_bank}};
	logic [mr-1:0][rw-1:0] pe_in_row = '0;
	logic out_valid;
	logic out_sop;
	logic out_eop;
	logic [data_w-1:0] out_real;
	logic [data_w-1:0] out_imag;
	logic busy;

	// packet under test, seen by the checker
	int pkt_dftpts = 0;
	int pkt_factor = 1;
	int pkt_stages = 0;
	logic [31:0] pkt_base = '0;
	logic [31:0] pkt_first = '0;
	logic [31:0] pkt_last = '0;
	int pkts_done;
	int check_errors;
	int pkts_passed;

	logic [31:0] stim [0:6*max_pkts-1];

	// groups in flight inside the engine model
	logic [mr-1:0][data_w-1:0] eq_real [$];
	logic [mr-1:0][data_w-1:0] eq_imag [$];
	logic [mr-1:0][bw-1:0] eq_bank [$];
	logic [mr-1:0][rw-1:0] eq_row [$];
	int eq_due [$];
	int cycle_n = 0;
	int last_due = 0;

	dft_mem_top #(.in_w(in_w), .data_w(data_w)) DUT (.*);

	tb_checker #(.in_w(in_w), .data_w(data_w)) u_checker (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//------------------------------------------------------------
	// engine model, slot j returns slot (j+1) mod factor
	//------------------------------------------------------------
	always @(negedge clk)
	begin
		int due;
		logic [mr-1:0][data_w-1:0] r_real;
		logic [mr-1:0][data_w-1:0] r_imag;
		cycle_n++;
		if (eq_due.size() > 0 && eq_due[0] <= cycle_n)
		begin
			pe_in_valid = 1'b1;
			pe_in_real = eq_real.pop_front();
			pe_in_imag = eq_imag.pop_front();
			pe_in_bank = eq_bank.pop_front();
			pe_in_row = eq_row.pop_front();
			void'(eq_due.pop_front());
		end
		else
		begin
			pe_in_valid = 1'b0;
			pe_in_bank = {mr{dft_mem_pkg::no_bank}};
		end
		if (rst_n && pe_out_valid)
		begin
			r_real = '0;
			r_imag = '0;
			for (int j = 0; j < pkt_factor; j++)
			begin
				r_real[j] = pe_out_real[(j + 1) % pkt_factor];
				r_imag[j] = pe_out_imag[(j + 1) % pkt_factor];
			end
			// one return per cycle, so later groups queue behind
			due = cycle_n + 1 + int'($urandom % 4);
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			eq_real.push_back(r_real);
			eq_imag.push_back(r_imag);
			eq_bank.push_back(pe_out_bank);
			eq_row.push_back(pe_out_row);
			eq_due.push_back(due);
		end
	end

	// one sample per cycle, settings held for the whole packet
	task automatic send_packet(input int num);
		dftpts = dft_mem_pkg::addr_w'(pkt_dftpts);
		factor = 3'(pkt_factor);
		stages = 3'(pkt_stages);
		for (int i = 0; i < num; i++)
		begin
			in_valid = 1'b1;
			in_sop = (i == 0);
			in_real = in_w'(pkt_base + 32'(i));
			in_imag = in_w'(32'd0 - pkt_base - 32'(i));
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_sop = 1'b0;
	endtask

	//------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------
	initial
	begin
		int p;
		int n;
		logic timed_out;
		void'($urandom(32'hd883_b653));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_sop = 1'b0;
		in_real = '0;
		in_imag = '0;
		dftpts = '0;
		factor = '0;
		stages = '0;
		$readmemh("tb_input.txt", stim);
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// idle stretch before the first sop
		repeat (6) @(negedge clk);
		timed_out = 1'b0;
		p = 0;
		while (!timed_out && p < max_pkts && stim[6*p] != 0)
		begin
			n = 0;
			while (busy && n < wait_limit)
			begin
				@(negedge clk);
				n++;
			end
			if (busy)
			begin
				$display("timeout: busy stayed high before packet %0d", p + 1);
				timed_out = 1'b1;
			end
			else
			begin
				pkt_dftpts = int'(stim[6*p]);
				pkt_factor = int'(stim[6*p+1]);
				pkt_stages = int'(stim[6*p+2]);
				pkt_base = stim[6*p+3];
				pkt_first = stim[6*p+4];
				pkt_last = stim[6*p+5];
				send_packet(pkt_dftpts);
				n = 0;
				while (pkts_done == p && n < wait_limit)
				begin
					@(negedge clk);
					n++;
				end
				if (pkts_done == p)
				begin
					$display("timeout: packet %0d never came out", p + 1);
					timed_out = 1'b1;
				end
			end
			p++;
		end
		repeat (4) @(negedge clk);
		$display("packets %0d of %0d, passed %0d, errors %0d, assertion failures %0d",
			pkts_done, p, pkts_passed, check_errors, DUT.u_asserts.fail_count);
		if (!timed_out && check_errors == 0 && DUT.u_asserts.fail_count == 0 &&
			pkts_done == p)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* tb_input.txt */
// columns (hex): dftpts factor stages base first_out_real last_out_real
// sample n of a packet is base+n, edge values are 30-bit sign-extended
023 5 1 00100 00000101 0000011e
01b 3 3 00200 00000200 0000021a
010 2 4 00300 00000300 0000030f
014 4 2 3fff0 3ffffff2 00000001
348 5 4 01000 00001004 00001346
02a 3 1 00000 00000001 00000027
006 2 1 00050 00000051 00000054
03c 4 3 1f000 0001f003 0001f03a
// end marker
000 0 0 00000 00000000 00000000

/* vlog.f */
dft_mem_pkg.sv
bank_array.sv
sink_writer.sv
group_reader.sv
result_writer.sv
source_reader.sv
mem_ctrl.sv
dft_mem_top.sv
tb_dft_mem_asserts.sv
tb_checker.sv
tb_dft_mem.sv

/* run.sh */
#!/bin/bash
# build the dft packet memory testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_dft_mem -f vlog.f -o tb_dft_mem_sim \
	|| { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/tb_dft_mem_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "Finished with no errors" \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
